// ==== cw_control_properties.sv ====
`timescale 1ns/1ns

module cw_control_properties (
	input logic clk,
	input logic reset,
	input logic reg_addrvalid_i,
	input logic [7:0] reg_data_i, // readback bus of the top level
	input logic [7:0] trigmod_i, // trigger module register
	input logic trigger_i, // selected trigger
	input logic power_off_i, // power-off bit straight from the register
	input logic fast_start_i,
	input logic targetpower_off_i
);

	logic off_meta; // own copy of the two-flop sync
	logic off_sync;

	always_ff @(posedge clk) begin
		if (reset) begin
			off_meta <= 1'b0;
			off_sync <= 1'b0;
		end else begin
			off_meta <= power_off_i;
			off_sync <= off_meta;
		end
	end

	// bus reads zero after an edge without address-valid
	readback_idle: assert property (@(posedge clk) disable iff (reset)
		!reg_addrvalid_i |=> reg_data_i == 8'd0)
		else $error("read data not zero after an edge with address-valid low");

	// select codes 4..7 keep the trigger low
	unused_module_low: assert property (@(posedge clk) disable iff (reset)
		trigmod_i[2:0] >= 3'd4 |-> !trigger_i)
		else $error("trigger high with an unused module select");

	// fast switch bypasses the pwm
	fast_follows_sync: assert property (@(posedge clk) disable iff (reset)
		fast_start_i |-> targetpower_off_i == off_sync)
		else $error("target power differs from the synced bit in fast mode");

endmodule

bind cw_control_top cw_control_properties cw_control_properties_inst (
	.clk(clk),
	.reset(reset),
	.reg_addrvalid_i(reg_addrvalid_i),
	.reg_data_i(reg_data_o),
	.trigmod_i(trigmod),
	.trigger_i(trigger_o),
	.power_off_i(ioroute.fields.extra.power_off),
	.fast_start_i(ioroute.fields.extra.fast_start),
	.targetpower_off_i(targetpower_off_o)
);

// ==== cw_control_top.sv ====
`timescale 1ns/1ns

module cw_control_top (
	input logic clk,
	input logic reset,
	// host bus
	input logic [5:0] reg_address_i,
	input logic [15:0] reg_bytecnt_i,
	input logic [7:0] reg_data_i,
	input logic reg_read_i,
	input logic reg_write_i,
	input logic reg_addrvalid_i,
	input logic [5:0] reg_hypaddress_i,
	// trigger sources
	input logic [5:0] trig_lines_i, // fa, fb, r1..r4
	input logic trigger_advio_i,
	input logic trigger_anapattern_i,
	input logic trigger_decodedio_i,
	output logic [7:0] reg_data_o,
	output logic [15:0] reg_hyplen_o,
	output logic trigger_ext_o,
	output logic trigger_o,
	output logic enable_avrprog_o,
	output logic targetpower_off_o
);

	logic [7:0] trigsrc; // trigger source register
	logic [7:0] trigmod; // trigger module register
	cw_reg_pkg::io_route_u ioroute; // io routing word

	cw_reg_file cw_reg_file_inst (
		.clk(clk),
		.reset(reset),
		.reg_address_i(reg_address_i),
		.reg_bytecnt_i(reg_bytecnt_i),
		.reg_data_i(reg_data_i),
		.reg_read_i(reg_read_i),
		.reg_write_i(reg_write_i),
		.reg_addrvalid_i(reg_addrvalid_i),
		.reg_hypaddress_i(reg_hypaddress_i),
		.reg_data_o(reg_data_o),
		.reg_hyplen_o(reg_hyplen_o),
		.trigsrc_o(trigsrc),
		.trigmod_o(trigmod),
		.ioroute_o(ioroute)
	);

	cw_trigger_route cw_trigger_route_inst (
		.trigsrc_i(trigsrc),
		.trigmod_i(trigmod),
		.trig_lines_i(trig_lines_i),
		.trigger_advio_i(trigger_advio_i),
		.trigger_anapattern_i(trigger_anapattern_i),
		.trigger_decodedio_i(trigger_decodedio_i),
		.trigger_ext_o(trigger_ext_o),
		.trigger_o(trigger_o)
	);

	cw_target_power cw_target_power_inst (
		.clk(clk),
		.reset(reset),
		.power_off_i(ioroute.fields.extra.power_off),
		.fast_start_i(ioroute.fields.extra.fast_start),
		.targetpower_off_o(targetpower_off_o)
	);

	assign enable_avrprog_o = ioroute.fields.extra.avr_prog; // straight from the register

endmodule

// ==== cw_reg_file.sv ====
`timescale 1ns/1ns

module cw_reg_file (
	input logic clk,
	input logic reset,
	input logic [5:0] reg_address_i, // host register address
	input logic [15:0] reg_bytecnt_i, // byte index within a multi-byte register
	input logic [7:0] reg_data_i, // write data
	input logic reg_read_i,
	input logic reg_write_i,
	input logic reg_addrvalid_i,
	input logic [5:0] reg_hypaddress_i, // address for the length lookup
	output logic [7:0] reg_data_o, // read data, one cycle after the strobe
	output logic [15:0] reg_hyplen_o, // length of reg_hypaddress_i in bytes
	output logic [7:0] trigsrc_o,
	output logic [7:0] trigmod_o,
	output cw_reg_pkg::io_route_u ioroute_o
);

	logic [7:0] trigsrc_q; // trigger source register
	logic [7:0] trigmod_q; // trigger module register
	cw_reg_pkg::io_route_u ioroute_q; // io routing register
	logic [cw_reg_pkg::IOROUTE_SEL_BITS-1:0] byte_sel; // io routing byte from bytecnt
	logic addr_mapped; // reg_address_i hits one of the three registers
	logic [7:0] rdata_q; // captured read value
	logic rvalid_q; // readback gate

	assign byte_sel = reg_bytecnt_i[cw_reg_pkg::IOROUTE_SEL_BITS-1:0];

	// decode of the live host address
	always_comb begin
		case (reg_address_i)
			cw_reg_pkg::TRIGSRC_ADDR,
			cw_reg_pkg::TRIGMOD_ADDR,
			cw_reg_pkg::IOROUTE_ADDR: addr_mapped = 1'b1;
			default: addr_mapped = 1'b0; // includes the old ext clock address
		endcase
	end

	// register writes
	always_ff @(posedge clk) begin
		if (reset) begin
			trigsrc_q <= cw_reg_pkg::TRIGSRC_RESET;
			trigmod_q <= cw_reg_pkg::TRIGMOD_RESET;
			ioroute_q <= cw_reg_pkg::IOROUTE_RESET;
		end else if (reg_write_i) begin
			case (reg_address_i)
				cw_reg_pkg::TRIGSRC_ADDR: trigsrc_q <= reg_data_i;
				cw_reg_pkg::TRIGMOD_ADDR: trigmod_q <= reg_data_i;
				cw_reg_pkg::IOROUTE_ADDR: ioroute_q.bytes[byte_sel] <= reg_data_i; // one byte
				default: ; // unmapped, write dropped
			endcase
		end
	end

	// read data capture on the read strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			rdata_q <= 8'd0;
		end else if (reg_read_i) begin
			case (reg_address_i)
				cw_reg_pkg::TRIGSRC_ADDR: rdata_q <= trigsrc_q;
				cw_reg_pkg::TRIGMOD_ADDR: rdata_q <= trigmod_q;
				cw_reg_pkg::IOROUTE_ADDR: rdata_q <= ioroute_q.bytes[byte_sel];
				default: rdata_q <= 8'd0;
			endcase
		end
	end

	// valid follows address-valid on every edge
	always_ff @(posedge clk) begin
		if (reset)
			rvalid_q <= 1'b0;
		else
			rvalid_q <= reg_addrvalid_i & addr_mapped;
	end

	assign reg_data_o = rvalid_q ? rdata_q : 8'd0; // bus idles at zero

	// length lookup for the host, purely combinational
	always_comb begin
		case (reg_hypaddress_i)
			cw_reg_pkg::TRIGSRC_ADDR: reg_hyplen_o = 16'd1;
			cw_reg_pkg::TRIGMOD_ADDR: reg_hyplen_o = 16'd1;
			cw_reg_pkg::IOROUTE_ADDR: reg_hyplen_o = cw_reg_pkg::IOROUTE_BYTES[15:0];
			default: reg_hyplen_o = 16'd0;
		endcase
	end

	assign trigsrc_o = trigsrc_q;
	assign trigmod_o = trigmod_q;
	assign ioroute_o = ioroute_q;

endmodule

// ==== cw_reg_pkg.sv ====
package cw_reg_pkg;

	// host register addresses, 6 bit address bus
	localparam logic [5:0] TRIGSRC_ADDR = 6'd39; // external trigger source / combine mode
	localparam logic [5:0] TRIGMOD_ADDR = 6'd40; // trigger module select
	localparam logic [5:0] IOROUTE_ADDR = 6'd55; // io routing, eight bytes

	// reset values
	localparam logic [7:0] TRIGSRC_RESET = 8'h01; // front A enabled, OR combine
	localparam logic [7:0] TRIGMOD_RESET = 8'h00; // edge module
	localparam logic [63:0] IOROUTE_RESET = 64'h0000_0000_0000_0201; // gpio1=1, gpio2=2

	localparam int IOROUTE_BYTES = 8;
	localparam int IOROUTE_SEL_BITS = $clog2(IOROUTE_BYTES); // byte select from bytecnt

	// trigger source layout: [7:6] combine mode, [5:0] line enables
	// line order fa, fb, r1, r2, r3, r4
	localparam int TRIG_LINES = 6;
	localparam int COMBINE_LSB = 6;
	localparam logic [1:0] COMBINE_OR = 2'd0;
	localparam logic [1:0] COMBINE_AND = 2'd1;

	// trigger module layout: [2:0] module select
	localparam int TRIGMOD_SEL_BITS = 3;
	localparam logic [2:0] TRIGMOD_EDGE = 3'd0; // combined external lines
	localparam logic [2:0] TRIGMOD_ADVIO = 3'd1; // advanced io pattern
	localparam logic [2:0] TRIGMOD_SAD = 3'd2; // analog pattern / sad
	localparam logic [2:0] TRIGMOD_DECODED = 3'd3; // decoded io

	// target power soft start, shortened for simulation
	localparam int PWM_BITS = 8;
	localparam logic [PWM_BITS-1:0] PWM_ON_COUNT = 8'd175; // pwm counts reading "off"
	localparam int SOFT_STEPS = 64; // pwm periods in the ramp
	localparam int STEP_BITS = $clog2(SOFT_STEPS) + 1; // must hold SOFT_STEPS itself

	// io routing word, byte view for host access and named field view
	typedef union packed {
		logic [IOROUTE_BYTES-1:0][7:0] bytes; // bytes[0] is gpio1
		struct packed {
			logic [7:0] reserved1;
			logic [7:0] reserved0;
			struct packed {
				logic [4:0] spare;
				logic fast_start; // 1 = fast switch, 0 = slow start
				logic power_off; // 1 = target unpowered
				logic avr_prog; // avr programming enable
			} extra;
			logic [7:0] glitch; // plain storage
			logic [7:0] gpio4;
			logic [7:0] gpio3;
			logic [7:0] gpio2;
			logic [7:0] gpio1;
		} fields;
	} io_route_u;

endpackage

// ==== cw_target_power.sv ====
`timescale 1ns/1ns

module cw_target_power (
	input logic clk,
	input logic reset,
	input logic power_off_i, // power-off bit from the extra byte
	input logic fast_start_i, // 1 = switch straight on, 0 = pwm soft start
	output logic targetpower_off_o // 1 = target switched off
);

	logic off_meta; // first sync stage
	logic off_sync; // second sync stage
	logic soft_on; // soft start armed
	logic [cw_reg_pkg::PWM_BITS-1:0] pwm_cnt;
	logic [cw_reg_pkg::STEP_BITS-1:0] step_cnt; // pwm periods elapsed
	logic pwm_wrap;
	logic ramp_active;
	logic pwm_off; // pwm phase reading "off"

	// two-flop synchronizer on the power-off bit
	always_ff @(posedge clk) begin
		if (reset) begin
			off_meta <= 1'b0;
			off_sync <= 1'b0;
		end else begin
			off_meta <= power_off_i;
			off_sync <= off_meta;
		end
	end

	// arm on off -> on, disarm whenever power goes off again
	always_ff @(posedge clk) begin
		if (reset)
			soft_on <= 1'b0;
		else if (!off_meta && off_sync)
			soft_on <= 1'b1;
		else if (off_meta)
			soft_on <= 1'b0;
	end

	assign pwm_wrap = &pwm_cnt;
	assign ramp_active = soft_on &&
		(step_cnt != cw_reg_pkg::SOFT_STEPS[cw_reg_pkg::STEP_BITS-1:0]);

	// pwm counter free runs while armed, step counter saturates at SOFT_STEPS
	always_ff @(posedge clk) begin
		if (reset || !soft_on) begin
			pwm_cnt <= '0;
			step_cnt <= '0;
		end else begin
			pwm_cnt <= pwm_cnt + 1'b1;
			if (pwm_wrap && ramp_active)
				step_cnt <= step_cnt + 1'b1; // one more period done
		end
	end

	assign pwm_off = pwm_cnt < cw_reg_pkg::PWM_ON_COUNT;

	// slow mode chops the switch during the ramp, otherwise follow the sync bit
	assign targetpower_off_o = (ramp_active && !fast_start_i) ? pwm_off : off_sync;

endmodule

// ==== cw_trigger_route.sv ====
`timescale 1ns/1ns

module cw_trigger_route (
	input logic [7:0] trigsrc_i, // line enables and combine mode
	input logic [7:0] trigmod_i, // module select in the low bits
	input logic [5:0] trig_lines_i, // fa, fb, r1..r4
	input logic trigger_advio_i,
	input logic trigger_anapattern_i,
	input logic trigger_decodedio_i,
	output logic trigger_ext_o, // combined external trigger
	output logic trigger_o // trigger to the capture logic
);

	logic [cw_reg_pkg::TRIG_LINES-1:0] line_en;
	logic [1:0] combine_mode;
	logic [cw_reg_pkg::TRIGMOD_SEL_BITS-1:0] mod_sel;
	logic trig_or; // any enabled line high
	logic trig_and; // all enabled lines high

	assign line_en = trigsrc_i[cw_reg_pkg::TRIG_LINES-1:0];
	assign combine_mode = trigsrc_i[cw_reg_pkg::COMBINE_LSB+1:cw_reg_pkg::COMBINE_LSB];
	assign mod_sel = trigmod_i[cw_reg_pkg::TRIGMOD_SEL_BITS-1:0];

	assign trig_or = |(line_en & trig_lines_i); // nothing enabled -> 0
	assign trig_and = &(~line_en | trig_lines_i); // disabled lines read as 1

	always_comb begin
		case (combine_mode)
			cw_reg_pkg::COMBINE_OR: trigger_ext_o = trig_or;
			cw_reg_pkg::COMBINE_AND: trigger_ext_o = trig_and;
			default: trigger_ext_o = 1'b0; // modes 2 and 3 unused
		endcase
	end

	// one trigger module feeds the capture logic
	always_comb begin
		case (mod_sel)
			cw_reg_pkg::TRIGMOD_EDGE: trigger_o = trigger_ext_o;
			cw_reg_pkg::TRIGMOD_ADVIO: trigger_o = trigger_advio_i;
			cw_reg_pkg::TRIGMOD_SAD: trigger_o = trigger_anapattern_i;
			cw_reg_pkg::TRIGMOD_DECODED: trigger_o = trigger_decodedio_i;
			default: trigger_o = 1'b0; // codes 4..7 held low
		endcase
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_cw_control --Mdir obj_dir
./obj_dir/Vtb_cw_control | tee sim.log
if grep -q "All checks passed" sim.log; then
	echo "simulation result: pass"
	exit 0
fi
echo "simulation result: fail"
exit 1

// ==== sources.f ====
cw_reg_pkg.sv
cw_reg_file.sv
cw_trigger_route.sv
cw_target_power.sv
cw_control_top.sv
cw_control_properties.sv
tb_cw_control.sv

// ==== tb_cw_control.sv ====
`timescale 1ns/1ns

module tb_cw_control;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	localparam int N_RW = 300; // random write/read pairs
	localparam int N_HYP = 100; // length lookups
	localparam int N_TRIG = 150; // trigger settings
	localparam int N_FAST = 24; // fast power switches
	localparam logic [15:0] EXTRA_BYTE = 16'd5; // byte count of the extra byte
	localparam int PWM_PERIOD = 1 << cw_reg_pkg::PWM_BITS;
	localparam int RAMP_CYCLES = cw_reg_pkg::SOFT_STEPS * PWM_PERIOD;
	// worst case length of every test plus slack
	localparam int RUN_CYCLES = RESET_CYCLES + 40 + N_RW * 3 + N_HYP * 2 + N_TRIG * 8
		+ N_FAST * 6 + RAMP_CYCLES + 6 * PWM_PERIOD + 500;

	logic clk;
	logic reset;
	logic [5:0] reg_address_i;
	logic [15:0] reg_bytecnt_i;
	logic [7:0] reg_data_i;
	logic reg_read_i;
	logic reg_write_i;
	logic reg_addrvalid_i;
	logic [5:0] reg_hypaddress_i;
	logic [5:0] trig_lines_i;
	logic trigger_advio_i;
	logic trigger_anapattern_i;
	logic trigger_decodedio_i;
	logic [7:0] reg_data_o;
	logic [15:0] reg_hyplen_o;
	logic trigger_ext_o;
	logic trigger_o;
	logic enable_avrprog_o;
	logic targetpower_off_o;

	logic [7:0] trigsrc_m; // shadow of the trigger source register
	logic [7:0] trigmod_m; // shadow of the module register
	cw_reg_pkg::io_route_u ioroute_m; // shadow io routing word
	integer seed = 32'hedf9;
	int pass_count = 0;
	int error_count = 0;
	int pass_mark = 0; // counts at the start of the running test
	int error_mark = 0;

	cw_control_top cw_control_top_inst (
		.clk(clk),
		.reset(reset),
		.reg_address_i(reg_address_i),
		.reg_bytecnt_i(reg_bytecnt_i),
		.reg_data_i(reg_data_i),
		.reg_read_i(reg_read_i),
		.reg_write_i(reg_write_i),
		.reg_addrvalid_i(reg_addrvalid_i),
		.reg_hypaddress_i(reg_hypaddress_i),
		.trig_lines_i(trig_lines_i),
		.trigger_advio_i(trigger_advio_i),
		.trigger_anapattern_i(trigger_anapattern_i),
		.trigger_decodedio_i(trigger_decodedio_i),
		.reg_data_o(reg_data_o),
		.reg_hyplen_o(reg_hyplen_o),
		.trigger_ext_o(trigger_ext_o),
		.trigger_o(trigger_o),
		.enable_avrprog_o(enable_avrprog_o),
		.targetpower_off_o(targetpower_off_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] next_random();
		return $random(seed);
	endfunction

	// expected readback per the register map
	function automatic logic [7:0] read_model(input logic [5:0] addr, input logic [15:0] cnt);
		case (addr)
			cw_reg_pkg::TRIGSRC_ADDR: return trigsrc_m;
			cw_reg_pkg::TRIGMOD_ADDR: return trigmod_m;
			cw_reg_pkg::IOROUTE_ADDR: return ioroute_m.bytes[cnt[2:0]];
			default: return 8'd0; // unmapped, 38 too
		endcase
	endfunction

	function automatic logic [15:0] hyplen_model(input logic [5:0] addr);
		case (addr)
			cw_reg_pkg::TRIGSRC_ADDR: return 16'd1;
			cw_reg_pkg::TRIGMOD_ADDR: return 16'd1;
			cw_reg_pkg::IOROUTE_ADDR: return 16'd8;
			default: return 16'd0;
		endcase
	endfunction

	// or / and over the enabled lines
	function automatic logic ext_model(input logic [7:0] src, input logic [5:0] lines);
		logic any_hit;
		logic all_hit;
		any_hit = 1'b0;
		all_hit = 1'b1; // nothing enabled reads as 1 in and mode
		for (int i = 0; i < cw_reg_pkg::TRIG_LINES; i++) begin
			if (src[i]) begin
				any_hit = any_hit | lines[i];
				all_hit = all_hit & lines[i];
			end
		end
		case (src[7:6])
			2'd0: return any_hit;
			2'd1: return all_hit;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic trig_model(input logic [7:0] mod, input logic ext,
			input logic advio, input logic ana, input logic dec);
		case (mod[2:0])
			3'd0: return ext;
			3'd1: return advio;
			3'd2: return ana;
			3'd3: return dec;
			default: return 1'b0;
		endcase
	endfunction

	task automatic report_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		error_count++;
	endtask

	task automatic end_test(input string name);
		$display("test %s done: %0d passed, %0d failed", name,
			pass_count - pass_mark, error_count - error_mark);
		pass_mark = pass_count;
		error_mark = error_count;
	endtask

	task automatic next_cycle(); // back to the drive point after the edge
		@(posedge clk);
		#1;
	endtask

	task automatic host_write(input logic [5:0] addr, input logic [15:0] cnt,
			input logic [7:0] data);
		reg_address_i = addr;
		reg_bytecnt_i = cnt;
		reg_data_i = data;
		reg_write_i = 1'b1;
		reg_addrvalid_i = 1'b1;
		next_cycle();
		reg_write_i = 1'b0;
		reg_addrvalid_i = 1'b0;
		case (addr)
			cw_reg_pkg::TRIGSRC_ADDR: trigsrc_m = data;
			cw_reg_pkg::TRIGMOD_ADDR: trigmod_m = data;
			cw_reg_pkg::IOROUTE_ADDR: ioroute_m.bytes[cnt[2:0]] = data; // low 3 bits pick the byte
			default: ;
		endcase
	endtask

	task automatic host_read_check(input logic [5:0] addr, input logic [15:0] cnt);
		logic [7:0] expected;
		expected = read_model(addr, cnt);
		reg_address_i = addr;
		reg_bytecnt_i = cnt;
		reg_read_i = 1'b1;
		reg_addrvalid_i = 1'b1;
		next_cycle();
		reg_read_i = 1'b0;
		reg_addrvalid_i = 1'b0;
		@(negedge clk); // data is valid for this whole cycle
		if (reg_data_o !== expected)
			report_error($sformatf("read addr %0d byte %0d got %h expected %h",
				addr, cnt[2:0], reg_data_o, expected));
		else
			pass_count++;
		next_cycle();
	endtask

	// watchdog
	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("timeout: tests still running after %0d ns", RUN_CYCLES * CLK_PERIOD);
		$display("Checks failed");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [5:0] addr;
		logic [15:0] cnt;
		logic [7:0] extra;
		logic exp_ext;
		logic exp_trig;
		logic stayed_low;
		int highs;
		int lows;
		clk = 1'b0;
		reset = 1'b1;
		reg_address_i = 6'd0;
		reg_bytecnt_i = 16'd0;
		reg_data_i = 8'd0;
		reg_read_i = 1'b0;
		reg_write_i = 1'b0;
		reg_addrvalid_i = 1'b0;
		reg_hypaddress_i = 6'd0;
		trig_lines_i = 6'd0;
		trigger_advio_i = 1'b0;
		trigger_anapattern_i = 1'b0;
		trigger_decodedio_i = 1'b0;
		trigsrc_m = cw_reg_pkg::TRIGSRC_RESET;
		trigmod_m = cw_reg_pkg::TRIGMOD_RESET;
		ioroute_m.bytes = cw_reg_pkg::IOROUTE_RESET;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;

		host_read_check(cw_reg_pkg::TRIGSRC_ADDR, 16'd0);
		host_read_check(cw_reg_pkg::TRIGMOD_ADDR, 16'd0);
		for (int b = 0; b < cw_reg_pkg::IOROUTE_BYTES; b++)
			host_read_check(cw_reg_pkg::IOROUTE_ADDR, 16'(b));
		if (enable_avrprog_o !== 1'b0 || targetpower_off_o !== 1'b0)
			report_error("avr enable or target power not low after reset");
		else
			pass_count++;
		end_test("reset_readback");

		for (int i = 0; i < N_RW; i++) begin
			r = next_random();
			case (r[2:0])
				3'd0, 3'd1: addr = cw_reg_pkg::IOROUTE_ADDR;
				3'd2: addr = cw_reg_pkg::TRIGSRC_ADDR;
				3'd3: addr = cw_reg_pkg::TRIGMOD_ADDR;
				3'd4: addr = 6'd38; // old ext clock register, now unmapped
				default: addr = r[13:8]; // mostly unmapped
			endcase
			cnt = r[31:16];
			r = next_random();
			host_write(addr, cnt, r[7:0]);
			if (enable_avrprog_o !== ioroute_m.fields.extra.avr_prog)
				report_error($sformatf("avr enable %b expected %b", enable_avrprog_o,
					ioroute_m.fields.extra.avr_prog));
			else
				pass_count++;
			host_read_check(addr, cnt);
		end
		end_test("write_readback");

		for (int i = 0; i < N_HYP; i++) begin
			r = next_random();
			case (r[1:0])
				2'd0: reg_hypaddress_i = cw_reg_pkg::TRIGSRC_ADDR;
				2'd1: reg_hypaddress_i = cw_reg_pkg::TRIGMOD_ADDR;
				2'd2: reg_hypaddress_i = cw_reg_pkg::IOROUTE_ADDR;
				default: reg_hypaddress_i = r[13:8];
			endcase
			@(negedge clk);
			if (reg_hyplen_o !== hyplen_model(reg_hypaddress_i))
				report_error($sformatf("length of addr %0d got %0d expected %0d",
					reg_hypaddress_i, reg_hyplen_o, hyplen_model(reg_hypaddress_i)));
			else
				pass_count++;
			next_cycle();
		end
		end_test("length_lookup");

		for (int i = 0; i < N_TRIG; i++) begin
			r = next_random();
			host_write(cw_reg_pkg::TRIGSRC_ADDR, 16'd0, r[7:0]);
			host_write(cw_reg_pkg::TRIGMOD_ADDR, 16'd0, r[15:8]);
			trig_lines_i = r[21:16];
			trigger_advio_i = r[22];
			trigger_anapattern_i = r[23];
			trigger_decodedio_i = r[24];
			exp_ext = ext_model(trigsrc_m, trig_lines_i);
			exp_trig = trig_model(trigmod_m, exp_ext, r[22], r[23], r[24]);
			@(negedge clk);
			if (trigger_ext_o !== exp_ext)
				report_error($sformatf("trigger_ext src %h lines %b got %b expected %b",
					trigsrc_m, trig_lines_i, trigger_ext_o, exp_ext));
			else
				pass_count++;
			if (trigger_o !== exp_trig)
				report_error($sformatf("trigger mod %h got %b expected %b",
					trigmod_m, trigger_o, exp_trig));
			else
				pass_count++;
			next_cycle();
		end
		end_test("trigger_combine");

		for (int i = 0; i < N_FAST; i++) begin
			r = next_random();
			extra = {5'd0, 1'b1, r[1], r[0]}; // fast start, random power and avr bits
			host_write(cw_reg_pkg::IOROUTE_ADDR, EXTRA_BYTE, extra);
			next_cycle();
			next_cycle(); // two sync stages
			if (targetpower_off_o !== r[1])
				report_error($sformatf("fast target power got %b expected %b",
					targetpower_off_o, r[1]));
			else
				pass_count++;
			if (enable_avrprog_o !== r[0])
				report_error($sformatf("avr enable got %b expected %b", enable_avrprog_o, r[0]));
			else
				pass_count++;
		end
		host_write(cw_reg_pkg::IOROUTE_ADDR, EXTRA_BYTE, 8'h02); // off, slow mode
		repeat (4) next_cycle();
		if (targetpower_off_o !== 1'b1)
			report_error($sformatf("target power got %b expected 1", targetpower_off_o));
		else
			pass_count++;
		host_write(cw_reg_pkg::IOROUTE_ADDR, EXTRA_BYTE, 8'h00); // on, soft start
		next_cycle();
		next_cycle(); // off bit through both sync stages, ramp armed
		highs = 0;
		lows = 0;
		repeat (RAMP_CYCLES) begin
			@(negedge clk);
			if (targetpower_off_o)
				highs++;
			else
				lows++;
		end
		if (highs == 0 || lows == 0)
			report_error($sformatf("soft start never chopped, %0d high and %0d low cycles",
				highs, lows));
		else
			pass_count++;
		repeat (2 * PWM_PERIOD) @(negedge clk); // ramp is over by now
		stayed_low = 1'b1;
		repeat (2 * PWM_PERIOD) begin
			@(negedge clk);
			if (targetpower_off_o !== 1'b0)
				stayed_low = 1'b0;
		end
		if (!stayed_low)
			report_error("target power still switching after the soft start");
		else
			pass_count++;
		end_test("target_power");

		$display("totals: %0d checks passed, %0d failed", pass_count, error_count);
		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule
